//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

   localparam int DATA_W      = 32;
   localparam int STRB_W      = DATA_W / 8;

   // word addressed
   localparam int ADDR_W      = 10;
   localparam int MEM_WORDS   = 2 ** ADDR_W;

   // 16 lines of 4 words
   localparam int WORD_OFF_W  = 2;
   localparam int NLINES_W    = 4;
   localparam int TAG_W       = ADDR_W - NLINES_W - WORD_OFF_W;
   localparam int NLINES      = 2 ** NLINES_W;
   localparam int CACHE_WORDS = 2 ** (NLINES_W + WORD_OFF_W);

   localparam int WTB_DEPTH_W = 2;

endpackage

`default_nettype wire

//--- design/ram_sp_be.sv
`default_nettype none

module ram_sp_be #(
   parameter int MEM_ADDR_W = cache_pkg::ADDR_W
) (
   input  wire                              clk,
   input  wire                              en,
   input  wire  [cache_pkg::STRB_W-1:0]     we,
   input  wire  [MEM_ADDR_W-1:0]            addr,
   input  wire  [cache_pkg::DATA_W-1:0]     din,
   output logic [cache_pkg::DATA_W-1:0]     dout
);

   // starts out all zero in simulation
   logic [cache_pkg::DATA_W-1:0] mem [0:(1<<MEM_ADDR_W)-1] = '{default: '0};

   always_ff @(posedge clk) begin
      if (en) begin
         for (int b = 0; b < cache_pkg::STRB_W; b++) begin
            if (we[b]) begin
               mem[addr][8*b +: 8] <= din[8*b +: 8];
            end
         end
         // read returns the old word on a write
         dout <= mem[addr];
      end
   end

endmodule

`default_nettype wire

//--- design/write_through_buf.sv
`default_nettype none

module write_through_buf #(
   parameter int DEPTH_W = cache_pkg::WTB_DEPTH_W
) (
   input  wire                              clk,
   input  wire                              rst_n,

   input  wire                              wtb_push,
   input  wire  [cache_pkg::ADDR_W-1:0]     wtb_addr,
   input  wire  [cache_pkg::DATA_W-1:0]     wtb_wdata,
   input  wire  [cache_pkg::STRB_W-1:0]     wtb_wstrb,
   output logic                             wtb_full,
   output logic                             wtb_empty,

   output logic                             drain_req,
   output logic [cache_pkg::ADDR_W-1:0]     drain_addr,
   output logic [cache_pkg::DATA_W-1:0]     drain_wdata,
   output logic [cache_pkg::STRB_W-1:0]     drain_wstrb,
   input  wire                              drain_ack
);

   logic [cache_pkg::ADDR_W-1:0] addr_q [0:(1<<DEPTH_W)-1];
   logic [cache_pkg::DATA_W-1:0] data_q [0:(1<<DEPTH_W)-1];
   logic [cache_pkg::STRB_W-1:0] strb_q [0:(1<<DEPTH_W)-1];

   logic [DEPTH_W-1:0]           wr_ptr;
   logic [DEPTH_W-1:0]           rd_ptr;
   logic [DEPTH_W:0]             count;
   logic                         in_flight;

   // count reaches 2**DEPTH_W exactly when full
   assign wtb_full  = count[DEPTH_W];
   assign wtb_empty = (count == '0) && !in_flight;

   // head entry stays put until its write is acknowledged
   assign drain_req   = (count != '0) && !in_flight;
   assign drain_addr  = addr_q[rd_ptr];
   assign drain_wdata = data_q[rd_ptr];
   assign drain_wstrb = strb_q[rd_ptr];

   always_ff @(posedge clk) begin
      if (wtb_push) begin
         addr_q[wr_ptr] <= wtb_addr;
         data_q[wr_ptr] <= wtb_wdata;
         strb_q[wr_ptr] <= wtb_wstrb;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         in_flight <= 1'b0;
      end else begin
         if (wtb_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (drain_ack) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         if (drain_req) begin
            in_flight <= 1'b1;
         end else if (drain_ack) begin
            in_flight <= 1'b0;
         end

         case ({wtb_push, drain_ack})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/backend_arbiter.sv
`default_nettype none

module backend_arbiter (
   input  wire                              clk,
   input  wire                              rst_n,

   input  wire                              fill_req,
   input  wire  [cache_pkg::ADDR_W-1:0]     fill_addr,
   output logic [cache_pkg::DATA_W-1:0]     fill_rdata,
   output logic                             fill_ack,

   input  wire                              drain_req,
   input  wire  [cache_pkg::ADDR_W-1:0]     drain_addr,
   input  wire  [cache_pkg::DATA_W-1:0]     drain_wdata,
   input  wire  [cache_pkg::STRB_W-1:0]     drain_wstrb,
   output logic                             drain_ack,

   output logic                             be_req,
   output logic [cache_pkg::ADDR_W-1:0]     be_addr,
   output logic [cache_pkg::DATA_W-1:0]     be_wdata,
   output logic [cache_pkg::STRB_W-1:0]     be_wstrb,
   input  wire  [cache_pkg::DATA_W-1:0]     be_rdata,
   input  wire                              be_ack
);

   logic busy;
   logic owner_drain;
   logic drain_hold;
   logic fill_hold;
   logic drain_want;
   logic fill_want;
   logic grant_drain;
   logic grant_fill;

   // a pulse that arrives while the port is busy is kept until granted
   assign drain_want  = drain_req || drain_hold;
   assign fill_want   = fill_req || fill_hold;

   // drain has fixed priority
   assign grant_drain = !busy && drain_want;
   assign grant_fill  = !busy && !drain_want && fill_want;

   assign be_req   = grant_drain || grant_fill;
   assign be_addr  = grant_drain ? drain_addr : fill_addr;
   assign be_wdata = drain_wdata;
   assign be_wstrb = grant_drain ? drain_wstrb : '0;

   assign fill_rdata = be_rdata;
   assign fill_ack   = be_ack && !owner_drain;
   assign drain_ack  = be_ack && owner_drain;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy        <= 1'b0;
         owner_drain <= 1'b0;
         drain_hold  <= 1'b0;
         fill_hold   <= 1'b0;
      end else begin
         if (be_req) begin
            busy        <= 1'b1;
            owner_drain <= grant_drain;
         end else if (be_ack) begin
            busy <= 1'b0;
         end

         if (grant_drain) begin
            drain_hold <= 1'b0;
         end else if (drain_req) begin
            drain_hold <= 1'b1;
         end

         if (grant_fill) begin
            fill_hold <= 1'b0;
         end else if (fill_req) begin
            fill_hold <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
   input  wire                              clk,
   input  wire                              rst_n,

   input  wire                              req,
   input  wire  [cache_pkg::ADDR_W-1:0]     addr,
   input  wire  [cache_pkg::DATA_W-1:0]     wdata,
   input  wire  [cache_pkg::STRB_W-1:0]     wstrb,
   output logic [cache_pkg::DATA_W-1:0]     rdata,
   output logic                             ack,

   input  wire                              invalidate_in,

   input  wire                              wtb_full,
   input  wire                              wtb_empty,
   output logic                             wtb_push,
   output logic [cache_pkg::ADDR_W-1:0]     wtb_addr,
   output logic [cache_pkg::DATA_W-1:0]     wtb_wdata,
   output logic [cache_pkg::STRB_W-1:0]     wtb_wstrb,

   output logic                             fill_req,
   output logic [cache_pkg::ADDR_W-1:0]     fill_addr,
   input  wire  [cache_pkg::DATA_W-1:0]     fill_rdata,
   input  wire                              fill_ack
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,
      S_WAIT_EMPTY,
      S_FILL,
      S_RESPOND
   } state_t;

   state_t state;

   logic [cache_pkg::TAG_W-1:0]      tag_mem  [0:cache_pkg::NLINES-1];
   logic [cache_pkg::DATA_W-1:0]     data_mem [0:cache_pkg::CACHE_WORDS-1];
   logic [cache_pkg::NLINES-1:0]     valid;

   logic [cache_pkg::TAG_W-1:0]      tag;
   logic [cache_pkg::NLINES_W-1:0]   index;
   logic [cache_pkg::WORD_OFF_W-1:0] offset;

   logic [cache_pkg::WORD_OFF_W-1:0] fill_cnt;
   logic                             fill_pend;
   logic                             fill_word;
   logic                             fill_last;

   logic                             is_read;
   logic                             hit;
   logic                             read_hit;
   logic                             store_go;

   // address split: tag | index | word offset
   assign tag    = addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
   assign index  = addr[cache_pkg::WORD_OFF_W +: cache_pkg::NLINES_W];
   assign offset = addr[cache_pkg::WORD_OFF_W-1:0];

   assign is_read  = (wstrb == '0);
   assign hit      = valid[index] && (tag_mem[index] == tag);
   assign read_hit = (state == S_LOOKUP) && is_read && hit;

   // a store completes as soon as the buffer has a free slot
   assign store_go = (state == S_LOOKUP) && !is_read && !wtb_full;

   assign ack   = read_hit || store_go || (state == S_RESPOND);
   assign rdata = data_mem[{index, offset}];

   // every store goes to memory, hit or miss
   assign wtb_push  = store_go;
   assign wtb_addr  = addr;
   assign wtb_wdata = wdata;
   assign wtb_wstrb = wstrb;

   // one word per request, next one only after the ack
   assign fill_req  = (state == S_FILL) && !fill_pend;
   assign fill_addr = {tag, index, fill_cnt};
   assign fill_word = (state == S_FILL) && fill_ack;
   assign fill_last = fill_word && (fill_cnt == '1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= S_IDLE;
         fill_cnt  <= '0;
         fill_pend <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (req) begin
                  state <= S_LOOKUP;
               end
            end
            S_LOOKUP: begin
               if (is_read && !hit) begin
                  state <= S_WAIT_EMPTY;
               end else if (ack) begin
                  state <= S_IDLE;
               end
            end
            S_WAIT_EMPTY: begin
               // memory must hold every queued store before the fill
               if (wtb_empty) begin
                  state <= S_FILL;
               end
            end
            S_FILL: begin
               if (fill_req) begin
                  fill_pend <= 1'b1;
               end
               if (fill_ack) begin
                  fill_pend <= 1'b0;
                  fill_cnt  <= fill_cnt + 1'b1;
               end
               if (fill_last) begin
                  state <= S_RESPOND;
               end
            end
            S_RESPOND: begin
               state <= S_IDLE;
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid <= '0;
      end else if (invalidate_in) begin
         valid <= '0;
      end else if (fill_last) begin
         valid[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_last) begin
         tag_mem[index] <= tag;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_word) begin
         data_mem[{index, fill_cnt}] <= fill_rdata;
      end else if (store_go && hit) begin
         // only the strobed bytes of the hit word
         for (int b = 0; b < cache_pkg::STRB_W; b++) begin
            if (wstrb[b]) begin
               data_mem[{index, offset}][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/cache_top.sv
`default_nettype none

module cache_top (
   input  wire                              clk,
   input  wire                              rst_n,

   input  wire                              req,
   input  wire  [cache_pkg::ADDR_W-1:0]     addr,
   input  wire  [cache_pkg::DATA_W-1:0]     wdata,
   input  wire  [cache_pkg::STRB_W-1:0]     wstrb,
   output wire  [cache_pkg::DATA_W-1:0]     rdata,
   output wire                              ack,

   input  wire                              invalidate_in,
   output wire                              wtb_empty
);

   logic                         wtb_push;
   logic [cache_pkg::ADDR_W-1:0] wtb_addr;
   logic [cache_pkg::DATA_W-1:0] wtb_wdata;
   logic [cache_pkg::STRB_W-1:0] wtb_wstrb;
   logic                         wtb_full;

   logic                         fill_req;
   logic [cache_pkg::ADDR_W-1:0] fill_addr;
   logic [cache_pkg::DATA_W-1:0] fill_rdata;
   logic                         fill_ack;

   logic                         drain_req;
   logic [cache_pkg::ADDR_W-1:0] drain_addr;
   logic [cache_pkg::DATA_W-1:0] drain_wdata;
   logic [cache_pkg::STRB_W-1:0] drain_wstrb;
   logic                         drain_ack;

   logic                         be_req;
   logic [cache_pkg::ADDR_W-1:0] be_addr;
   logic [cache_pkg::DATA_W-1:0] be_wdata;
   logic [cache_pkg::STRB_W-1:0] be_wstrb;
   logic [cache_pkg::DATA_W-1:0] be_rdata;
   logic                         be_ack;

   cache_ctrl i_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .rdata         (rdata),
      .ack           (ack),
      .invalidate_in (invalidate_in),
      .wtb_full      (wtb_full),
      .wtb_empty     (wtb_empty),
      .wtb_push      (wtb_push),
      .wtb_addr      (wtb_addr),
      .wtb_wdata     (wtb_wdata),
      .wtb_wstrb     (wtb_wstrb),
      .fill_req      (fill_req),
      .fill_addr     (fill_addr),
      .fill_rdata    (fill_rdata),
      .fill_ack      (fill_ack)
   );

   write_through_buf i_wtb (
      .clk         (clk),
      .rst_n       (rst_n),
      .wtb_push    (wtb_push),
      .wtb_addr    (wtb_addr),
      .wtb_wdata   (wtb_wdata),
      .wtb_wstrb   (wtb_wstrb),
      .wtb_full    (wtb_full),
      .wtb_empty   (wtb_empty),
      .drain_req   (drain_req),
      .drain_addr  (drain_addr),
      .drain_wdata (drain_wdata),
      .drain_wstrb (drain_wstrb),
      .drain_ack   (drain_ack)
   );

   backend_arbiter i_arb (
      .clk         (clk),
      .rst_n       (rst_n),
      .fill_req    (fill_req),
      .fill_addr   (fill_addr),
      .fill_rdata  (fill_rdata),
      .fill_ack    (fill_ack),
      .drain_req   (drain_req),
      .drain_addr  (drain_addr),
      .drain_wdata (drain_wdata),
      .drain_wstrb (drain_wstrb),
      .drain_ack   (drain_ack),
      .be_req      (be_req),
      .be_addr     (be_addr),
      .be_wdata    (be_wdata),
      .be_wstrb    (be_wstrb),
      .be_rdata    (be_rdata),
      .be_ack      (be_ack)
   );

   ram_sp_be i_ram (
      .clk  (clk),
      .en   (be_req),
      .we   (be_wstrb),
      .addr (be_addr),
      .din  (be_wdata),
      .dout (be_rdata)
   );

   // native memory answers one clock after the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         be_ack <= 1'b0;
      end else begin
         be_ack <= be_req;
      end
   end

endmodule

`default_nettype wire

//--- include/cache_tb_ref.svh
`ifndef CACHE_TB_REF_SVH
`define CACHE_TB_REF_SVH

// flat image of backing memory, zero at start like the RAM
logic [cache_pkg::DATA_W-1:0] ref_mem [0:cache_pkg::MEM_WORDS-1] = '{default: '0};

// merge the strobed bytes into the model word
function automatic void ref_write(
   input logic [cache_pkg::ADDR_W-1:0] a,
   input logic [cache_pkg::DATA_W-1:0] d,
   input logic [cache_pkg::STRB_W-1:0] s
);
   logic [cache_pkg::DATA_W-1:0] word;
   word = ref_mem[a];
   for (int b = 0; b < cache_pkg::STRB_W; b++) begin
      if (s[b]) begin
         word[8*b +: 8] = d[8*b +: 8];
      end
   end
   ref_mem[a] = word;
endfunction

// expected word for a read at this address
function automatic logic [cache_pkg::DATA_W-1:0] ref_read(
   input logic [cache_pkg::ADDR_W-1:0] a
);
   return ref_mem[a];
endfunction

`endif

//--- tests/cache_tb.sv
`default_nettype none

module cache_tb;

   localparam int N_DIRECTED  = 44;
   localparam int N_RANDOM    = 300;
   // a miss queued behind a full buffer is the slowest access
   localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * 40 + 200;

   logic                         clk;
   logic                         rst_n;
   logic                         req;
   logic [cache_pkg::ADDR_W-1:0] addr;
   logic [cache_pkg::DATA_W-1:0] wdata;
   logic [cache_pkg::STRB_W-1:0] wstrb;
   logic [cache_pkg::DATA_W-1:0] rdata;
   logic                         ack;
   logic                         invalidate_in;
   logic                         wtb_empty;

   logic                         check_read;
   logic [cache_pkg::ADDR_W-1:0] exp_addr;
   logic [cache_pkg::DATA_W-1:0] exp_rdata;
   int                           cycle_cnt = 0;
   int                           seed;

   `include "cache_tb_ref.svh"

   cache_top i_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .rdata         (rdata),
      .ack           (ack),
      .invalidate_in (invalidate_in),
      .wtb_empty     (wtb_empty)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   // one front-end access, called 1 unit after a rising edge
   task automatic access(
      input  logic [cache_pkg::ADDR_W-1:0] a,
      input  logic [cache_pkg::DATA_W-1:0] d,
      input  logic [cache_pkg::STRB_W-1:0] s,
      output int                           cycles
   );
      if (s == '0) begin
         exp_addr   = a;
         exp_rdata  = ref_read(a);
         check_read = 1'b1;
      end else begin
         ref_write(a, d, s);
      end
      req    = 1'b1;
      addr   = a;
      wdata  = d;
      wstrb  = s;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!ack);
      #1;
      req        = 1'b0;
      wstrb      = '0;
      check_read = 1'b0;
   endtask

   task automatic wait_drained();
      while (!wtb_empty) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic pulse_invalidate();
      invalidate_in = 1'b1;
      @(posedge clk);
      #1;
      invalidate_in = 1'b0;
   endtask

   // read data checked in the ack cycle
   always @(posedge clk) begin
      if (ack && check_read) begin
         assert (rdata === exp_rdata)
            else stop_with_error($sformatf("MISMATCH rdata addr %h expected %h got %h",
                                           exp_addr, exp_rdata, rdata));
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > CYCLE_LIMIT) begin
         stop_with_error($sformatf("timeout: run did not finish within %0d cycles",
                                   CYCLE_LIMIT));
      end
   end

   initial begin
      int                           lat;
      logic [cache_pkg::ADDR_W-1:0] a;
      logic [cache_pkg::DATA_W-1:0] d;
      logic [cache_pkg::STRB_W-1:0] s;
      logic [31:0]                  r;

      seed          = 99156;
      rst_n         = 1'b0;
      req           = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      check_read    = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // idle straight out of reset
      assert (wtb_empty === 1'b1)
         else stop_with_error($sformatf("MISMATCH wtb_empty expected %h got %h",
                                        1'b1, wtb_empty));
      assert (ack === 1'b0)
         else stop_with_error($sformatf("MISMATCH ack expected %h got %h", 1'b0, ack));

      // store past the cache, then miss and hit on that line
      access(10'h014, 32'hCAFE_1234, 4'hF, lat);
      access(10'h014, '0, '0, lat);
      access(10'h015, '0, '0, lat);
      assert (lat == 2)
         else stop_with_error($sformatf("read hit acked after %0d cycles instead of 2", lat));
      access(10'h014, '0, '0, lat);
      assert (lat == 2)
         else stop_with_error($sformatf("read hit acked after %0d cycles instead of 2", lat));

      // full and partial stores, hit and miss
      access(10'h020, '0, '0, lat);
      access(10'h020, 32'h1122_3344, 4'hF, lat);
      access(10'h021, 32'hAABB_CCDD, 4'b0101, lat);
      access(10'h024, 32'h5566_7788, 4'b1000, lat);
      for (int i = 0; i < 6; i++) begin
         access(10'h020 + 10'(i), '0, '0, lat);
      end

      // eight stores to distinct lines, back to back
      for (int i = 0; i < 8; i++) begin
         a = 10'h200 + 10'(4 * i);
         access(a, 32'hA500_0000 | 32'(i), 4'hF, lat);
      end
      // last store still queued
      assert (wtb_empty === 1'b0)
         else stop_with_error($sformatf("MISMATCH wtb_empty expected %h got %h",
                                        1'b0, wtb_empty));
      wait_drained();
      for (int i = 0; i < 8; i++) begin
         access(10'h200 + 10'(4 * i), '0, '0, lat);
      end

      // cached lines get stores, then all valid bits drop
      for (int i = 0; i < 4; i++) begin
         a = 10'h100 + 10'(4 * i);
         access(a, '0, '0, lat);
         access(a, 32'h0F0F_0000 | 32'(i), 4'b0011, lat);
      end
      pulse_invalidate();
      // each of these lines must be fetched again
      for (int i = 0; i < 4; i++) begin
         access(10'h100 + 10'(4 * i), '0, '0, lat);
         assert (lat > 2)
            else stop_with_error($sformatf("invalidated line hit after %0d cycles", lat));
      end
      access(10'h014, '0, '0, lat);
      access(10'h021, '0, '0, lat);
      assert (lat > 2)
         else stop_with_error($sformatf("invalidated line hit after %0d cycles", lat));

      // 4 tags x 4 indexes x 4 words, tags collide on each index
      for (int n = 0; n < N_RANDOM; n++) begin
         r = $random(seed);
         a = {2'b01, r[5:4], 2'b00, r[3:2], r[1:0]};
         s = r[8] ? r[15:12] : 4'h0;
         d = $random(seed);
         access(a, d, s, lat);
      end

      wait_drained();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
design/cache_pkg.sv
design/ram_sp_be.sv
design/write_through_buf.sv
design/backend_arbiter.sv
design/cache_ctrl.sv
design/cache_top.sv
tests/cache_tb.sv
